//--- instDecode.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/aluDecoder.sv
hw/flowDecoder.sv
hw/ctrlMerge.sv
hw/instDecode.sv
sim/tbClock.sv
sim/tbInstDecode.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tbInstDecode \
		-f instDecode.f -o simInstDecode &&
	./obj_dir/simInstDecode | tee /dev/stderr | grep -qx "Done: no errors" &&
	{ echo "run.sh: PASS"; exit 0; } ||
	{ echo "run.sh: FAIL"; exit 1; }

//--- sim/tbInstDecode.sv
`timescale 1ns/1ps
`default_nettype none

module tbInstDecode
	import isaPkg::*;
	import ctrlPkg::*;
();

	localparam int ResetCycles = 10;
	localparam int TestCycles  = 3000;
	localparam int ClkPeriod   = 4;

	logic      clk;
	logic      rstN;
	logic      instValid;
	instWord_t instruction;
	flags_t    flags;
	logic      ctrlValid;
	ctrlWord_t ctrl;

	// Inputs as the DUT saw them at the last rising edge
	logic      prevRstN;
	logic      prevValid;
	instWord_t prevInst;
	flags_t    prevFlags;
	ctrlWord_t expCtrl;

	logic [31:0] rnd;
	int          errors = 0;
	int          checks = 0;

	tbClock i_tbClock (
		.clk(clk)
	);

	instDecode i_instDecode (
		.clk        (clk),
		.rstN       (rstN),
		.instValid  (instValid),
		.instruction(instruction),
		.flags      (flags),
		.ctrlValid  (ctrlValid),
		.ctrl       (ctrl)
	);

	function automatic logic [31:0] nextRandom(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Steer a random word into one instruction class
	function automatic instWord_t shapeInstruction(logic [31:0] r);
		instWord_t w;
		w = r[27:10];
		case (r[31:29])
			3'd0: w[17:12] = 6'b000000;
			3'd1: w[17:16] = 2'b00;
			3'd2: begin
				w[17:12] = 6'b000001;
				w[7:5]   = 3'b000;
			end
			3'd3: w[17:16] = 2'b01;
			3'd4, 3'd5: w[17:16] = 2'b10;
			// Class 11 holds no legal instruction
			3'd6: w[17:16] = 2'b11;
			default: ;
		endcase
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference decode
	//////////////////////////////////////////////////////////////////////

	// Flag bits are low, negative and zero from bit 2 down
	function automatic ctrlWord_t expectedCtrl(instWord_t w, flags_t f);
		ctrlWord_t c;
		regSel_t   ra;
		aluOp_t    op;
		logic      imm;
		logic      taken;
		c   = IdleCtrl;
		ra  = w[11:8];
		imm = w[15:12] > 4'd1;
		op  = imm ? w[15:12] : w[7:4];
		case (w[15:13])
			3'd0: taken = f[1];
			3'd1: taken = f[1] | f[0];
			3'd2: taken = !f[0];
			3'd3: taken = f[0];
			3'd4: taken = 1'b1;
			3'd5: taken = f[2] | f[0];
			3'd6: taken = f[2];
			default: taken = 1'b0;
		endcase
		if (w[17:16] == 2'b00 && (imm || (w[15:12] == 4'd0 && op > 4'd1))) begin
			c.aluOp     = op;
			c.bSrc      = imm ? BSrcImm : BSrcReg;
			c.immediate = imm ? {8'd0, w[7:0]} : 16'd0;
			c.readSel1  = ra;
			c.readSel2  = imm ? ra : w[3:0];
			c.destSel   = ra;
			c.destSel2  = ra;
			c.flagWrite = op != OpMovr;
			if (!imm && op == OpSub) begin
				c.readSel1 = w[3:0];
				c.readSel2 = ra;
			end
			if (op == OpMul) begin
				c.destSel  = 4'd11;
				c.destSel2 = 4'd12;
				c.writeEn1 = 1'b1;
				c.writeEn2 = 1'b1;
				c.wbSrc    = WbAlu;
				c.mulWide  = 1'b1;
			end else if (op != OpCmp && op != OpCmpr) begin
				c.wbSrc    = (op == OpMovr) ? WbMove : WbAlu;
				c.writeEn2 = ra inside {4'd12, 4'd13};
				c.writeEn1 = !c.writeEn2;
			end
		end else if (w[17:12] == 6'b000001 && w[7:5] == 3'd0) begin
			// MOVMR or MOVRM with the address register in the low nibble
			c.readSel1 = ra;
			c.readSel2 = w[3:0];
			c.destSel  = ra;
			c.destSel2 = ra;
			c.memRead  = !w[4];
			c.memWrite = w[4];
			if (!w[4]) begin
				c.wbSrc    = WbMem;
				c.writeEn2 = ra inside {4'd12, 4'd13};
				c.writeEn1 = !c.writeEn2;
			end
		end else if (w[17:16] == 2'b10 && w[15:13] != 3'd7) begin
			c.readSel1 = PcReg;
			c.addr     = {3'd0, w[12:0]};
			c.pcSrc    = taken ? PcJump : PcNext;
		end else if (w[17:16] == 2'b01) begin
			c.readSel1 = PcReg;
			case (w[15:14])
				2'd0: begin
					c.pcSrc    = PcJump;
					c.memWrite = 1'b1;
					c.readSel2 = 4'd13;
					c.destSel2 = 4'd13;
					c.writeEn2 = 1'b1;
					c.wbSrc    = WbPc;
					c.addr     = {2'd0, w[13:0]};
				end
				2'd1: begin
					c.memRead  = 1'b1;
					c.writeEn1 = 1'b1;
					c.wbSrc    = WbMem;
					c.addr     = {2'd0, w[13:0]};
				end
				2'd2: begin
					c.memWrite = 1'b1;
					c.addr     = {2'd0, w[13:0]};
				end
				default: begin
					c.pcSrc    = PcStack;
					c.memRead  = 1'b1;
					c.readSel2 = 4'd13;
					c.ret      = 1'b1;
				end
			endcase
		end
		return c;
	endfunction

	task automatic reportMismatch(string name, logic [15:0] expVal, logic [15:0] actVal);
		errors++;
		$display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
	endtask

	// One random instruction, flag set and valid bit
	task automatic driveRandomSlot();
		rnd         = nextRandom(rnd);
		instruction = shapeInstruction(rnd);
		rnd         = nextRandom(rnd);
		flags       = rnd[31:29];
		// Roughly one empty slot in eight
		instValid   = rnd[28:26] != 3'd0;
	endtask

	always @(posedge clk) begin
		prevRstN  <= rstN;
		prevValid <= instValid;
		prevInst  <= instruction;
		prevFlags <= flags;
	end

	always_comb begin
		if (prevRstN && prevValid) begin
			expCtrl = expectedCtrl(prevInst, prevFlags);
		end else begin
			expCtrl = IdleCtrl;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks at the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) checks <= checks + 1;

	validCheck: assert property (@(negedge clk) ctrlValid == (prevRstN && prevValid))
		else reportMismatch("ctrlValid", 16'(prevRstN && prevValid), 16'(ctrlValid));
	aluOpCheck: assert property (@(negedge clk) ctrl.aluOp == expCtrl.aluOp)
		else reportMismatch("aluOp", 16'(expCtrl.aluOp), 16'(ctrl.aluOp));
	srcCheck: assert property (@(negedge clk) {ctrl.bSrc, ctrl.wbSrc, ctrl.pcSrc} ==
		{expCtrl.bSrc, expCtrl.wbSrc, expCtrl.pcSrc})
		else reportMismatch("{bSrc,wbSrc,pcSrc}", 16'({expCtrl.bSrc, expCtrl.wbSrc,
			expCtrl.pcSrc}), 16'({ctrl.bSrc, ctrl.wbSrc, ctrl.pcSrc}));
	writeEnCheck: assert property (@(negedge clk)
		{ctrl.writeEn1, ctrl.writeEn2} == {expCtrl.writeEn1, expCtrl.writeEn2})
		else reportMismatch("{writeEn1,writeEn2}", 16'({expCtrl.writeEn1, expCtrl.writeEn2}),
			16'({ctrl.writeEn1, ctrl.writeEn2}));
	destCheck: assert property (@(negedge clk)
		{ctrl.destSel, ctrl.destSel2} == {expCtrl.destSel, expCtrl.destSel2})
		else reportMismatch("{destSel,destSel2}", 16'({expCtrl.destSel, expCtrl.destSel2}),
			16'({ctrl.destSel, ctrl.destSel2}));
	readCheck: assert property (@(negedge clk)
		{ctrl.readSel1, ctrl.readSel2} == {expCtrl.readSel1, expCtrl.readSel2})
		else reportMismatch("{readSel1,readSel2}", 16'({expCtrl.readSel1, expCtrl.readSel2}),
			16'({ctrl.readSel1, ctrl.readSel2}));
	immCheck: assert property (@(negedge clk) ctrl.immediate == expCtrl.immediate)
		else reportMismatch("immediate", expCtrl.immediate, ctrl.immediate);
	addrCheck: assert property (@(negedge clk) ctrl.addr == expCtrl.addr)
		else reportMismatch("addr", expCtrl.addr, ctrl.addr);
	// flagWrite, memRead, memWrite, ret, mulWide from the top bit down
	strobeCheck: assert property (@(negedge clk)
		{ctrl.flagWrite, ctrl.memRead, ctrl.memWrite, ctrl.ret, ctrl.mulWide} ==
		{expCtrl.flagWrite, expCtrl.memRead, expCtrl.memWrite, expCtrl.ret, expCtrl.mulWide})
		else reportMismatch("{flagWrite,memRead,memWrite,ret,mulWide}",
			16'({expCtrl.flagWrite, expCtrl.memRead, expCtrl.memWrite, expCtrl.ret,
			expCtrl.mulWide}), 16'({ctrl.flagWrite, ctrl.memRead, ctrl.memWrite, ctrl.ret,
			ctrl.mulWide}));

	//////////////////////////////////////////////////////////////////////
	// Stimulus and report
	//////////////////////////////////////////////////////////////////////

	initial begin
		rstN        = 1'b0;
		instValid   = 1'b0;
		instruction = '0;
		flags       = '0;
		rnd         = 32'h2b77_5bb5;
		// Valid instructions during reset must still come out idle
		for (int n = 0; n < ResetCycles; n++) begin
			driveRandomSlot();
			instValid = 1'b1;
			@(posedge clk);
			#1;
		end
		rstN = 1'b1;
		for (int n = 0; n < TestCycles; n++) begin
			driveRandomSlot();
			@(posedge clk);
			#1;
		end
		instValid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		#1;
		$display("Checked %0d cycles, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Whole test length plus 50 cycles of slack
	initial begin
		#((ResetCycles + TestCycles + 50) * ClkPeriod);
		$display("Watchdog timeout: stimulus did not finish in time");
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);

	// 4 ns period, first rising edge at 2 ns
	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- hw/instDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instDecode
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  wire            clk,
	input  wire            rstN,
	input  wire            instValid,
	input  wire instWord_t instruction,
	input  wire flags_t    flags,
	output logic           ctrlValid,
	output ctrlWord_t      ctrl
);

	decodeResult_t aluResult;
	decodeResult_t flowResult;

	// Normal class
	aluDecoder i_aluDecoder (
		.instruction(instruction),
		.result     (aluResult)
	);

	// Jumps, CALL, RET and immediate-address moves
	flowDecoder i_flowDecoder (
		.instruction(instruction),
		.flags      (flags),
		.result     (flowResult)
	);

	ctrlMerge i_ctrlMerge (
		.clk       (clk),
		.rstN      (rstN),
		.instValid (instValid),
		.aluResult (aluResult),
		.flowResult(flowResult),
		.ctrlValid (ctrlValid),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

//--- hw/ctrlMerge.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlMerge
	import ctrlPkg::*;
(
	input  wire                clk,
	input  wire                rstN,
	input  wire                instValid,
	input  wire decodeResult_t aluResult,
	input  wire decodeResult_t flowResult,
	output logic               ctrlValid,
	output ctrlWord_t          ctrl
);

	ctrlWord_t nextCtrl;

	// Illegal encodings and empty slots both fall back to idle
	always_comb begin
		if (!instValid) begin
			nextCtrl = IdleCtrl;
		end else if (aluResult.claim) begin
			nextCtrl = aluResult.ctrl;
		end else if (flowResult.claim) begin
			nextCtrl = flowResult.ctrl;
		end else begin
			nextCtrl = IdleCtrl;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlValid <= 1'b0;
			ctrl      <= IdleCtrl;
		end else begin
			ctrlValid <= instValid;
			ctrl      <= nextCtrl;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// The two decoders own disjoint encodings
	assert property (@(posedge clk) disable iff (!rstN)
		!(aluResult.claim && flowResult.claim))
		else $error("ctrlMerge: both decoders claimed");

	assert property (@(posedge clk)
		!ctrlValid |-> !(ctrl.writeEn1 || ctrl.writeEn2 || ctrl.memRead || ctrl.memWrite))
		else $error("ctrlMerge: enable set in an invalid slot");

endmodule

`default_nettype wire

//--- hw/flowDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module flowDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  wire instWord_t instruction,
	input  wire flags_t    flags,
	output decodeResult_t  result
);

	instClass_t instClass;
	specOp_t    specOp;
	jumpOp_t    jumpOp;
	imm_t       jumpAddr;
	imm_t       memAddr;
	logic       specClass;
	logic       isJump;
	logic       taken;

	assign instClass = instruction[17:16];
	assign specOp    = instruction[17:14];
	assign jumpOp    = instruction[17:13];
	assign jumpAddr  = {3'd0, instruction[12:0]};
	assign memAddr   = {2'd0, instruction[13:0]};

	// Class 11 held the stack ops and INCR/DECR, now illegal
	assign specClass = (instClass == ClsSpecLo) || (instClass == ClsSpecHi);

	//////////////////////////////////////////////////////////////////////
	// Jump conditions
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		isJump = 1'b1;
		case (jumpOp)
			OpJl:  taken = flags[FlagNeg];
			OpJle: taken = flags[FlagNeg] | flags[FlagZero];
			OpJne: taken = !flags[FlagZero];
			OpJe:  taken = flags[FlagZero];
			OpJ:   taken = 1'b1;
			OpJbe: taken = flags[FlagLow] | flags[FlagZero];
			OpJb:  taken = flags[FlagLow];
			default: begin
				isJump = 1'b0;
				taken  = 1'b0;
			end
		endcase
	end

	always_comb begin
		result.claim = 1'b0;
		result.ctrl  = IdleCtrl;

		if (specClass && isJump) begin
			result.claim      = 1'b1;
			result.ctrl.addr  = jumpAddr;
			result.ctrl.pcSrc = taken ? PcJump : PcNext;
		end else if (specClass) begin
			case (specOp)
				OpCall: begin
					// Return address pushed, SP updated through port 2
					result.claim         = 1'b1;
					result.ctrl.pcSrc    = PcJump;
					result.ctrl.memWrite = 1'b1;
					result.ctrl.readSel2 = StackPtrReg;
					result.ctrl.destSel2 = StackPtrReg;
					result.ctrl.writeEn2 = 1'b1;
					result.ctrl.wbSrc    = WbPc;
					result.ctrl.addr     = memAddr;
				end
				OpRet: begin
					result.claim         = 1'b1;
					result.ctrl.pcSrc    = PcStack;
					result.ctrl.memRead  = 1'b1;
					result.ctrl.readSel2 = StackPtrReg;
					result.ctrl.ret      = 1'b1;
				end
				OpMovmri: begin
					// No register field, the load lands in r0
					result.claim         = 1'b1;
					result.ctrl.memRead  = 1'b1;
					result.ctrl.writeEn1 = 1'b1;
					result.ctrl.wbSrc    = WbMem;
					result.ctrl.addr     = memAddr;
				end
				OpMovrmi: begin
					result.claim         = 1'b1;
					result.ctrl.memWrite = 1'b1;
					result.ctrl.addr     = memAddr;
				end
				default: begin
					result.claim = 1'b0;
				end
			endcase
		end

		// Every flow instruction reads the PC on port 1
		if (result.claim) begin
			result.ctrl.readSel1 = PcReg;
		end
	end

	// Popping the PC is what RET does and nothing else
	always_comb begin
		if (result.ctrl.pcSrc == PcStack) begin
			assert (result.ctrl.ret)
				else $error("flowDecoder: stack PC source without ret");
		end
	end

endmodule

`default_nettype wire

//--- hw/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  wire instWord_t instruction,
	output decodeResult_t  result
);

	instClass_t instClass;
	group_t     group;
	regSel_t    regA;
	regSel_t    regB;
	aluOp_t     fnCode;
	aluOp_t     op;
	logic       regForm;
	logic       immForm;
	logic       memGroup;
	logic       isAluOp;

	// r12 and r13 sit behind the second write port
	function automatic logic onSecondPort(regSel_t r);
		return (r == SecondPortLo) || (r == StackPtrReg);
	endfunction

	assign instClass = instruction[17:16];
	assign group     = instruction[15:12];
	assign regA      = instruction[11:8];
	assign regB      = instruction[3:0];
	assign fnCode    = instruction[7:4];

	assign regForm  = (instClass == ClsNormal) && (group == GrpRegForm);
	assign memGroup = (instClass == ClsNormal) && (group == GrpRegOnly);
	assign immForm  = (instClass == ClsNormal) && !regForm && !memGroup;

	// Immediate form keeps its opcode where the group would be
	assign op = immForm ? group : fnCode;

	assign isAluOp = op inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpNot, OpLsh,
		OpRsh, OpArsh, OpFmul, OpMul, OpCmp, OpCmpr, OpMovr};

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		result.claim = 1'b0;
		result.ctrl  = IdleCtrl;

		if ((regForm || immForm) && isAluOp) begin
			result.claim          = 1'b1;
			result.ctrl.aluOp     = op;
			result.ctrl.bSrc      = immForm ? BSrcImm : BSrcReg;
			result.ctrl.immediate = immForm ? {8'd0, instruction[7:0]} : 16'd0;
			result.ctrl.readSel1  = regA;
			result.ctrl.readSel2  = immForm ? regA : regB;
			result.ctrl.destSel   = regA;
			result.ctrl.destSel2  = regA;
			result.ctrl.flagWrite = (op != OpMovr);

			// Register SUB is reversed so the immediate form can use B as subtrahend
			if (regForm && (op == OpSub)) begin
				result.ctrl.readSel1 = regB;
				result.ctrl.readSel2 = regA;
			end

			case (op)
				OpCmp, OpCmpr: begin
					// flags only
					result.ctrl.wbSrc = WbNone;
				end
				OpMul: begin
					result.ctrl.destSel  = MulHiReg;
					result.ctrl.destSel2 = SecondPortLo;
					result.ctrl.writeEn1 = 1'b1;
					result.ctrl.writeEn2 = 1'b1;
					result.ctrl.wbSrc    = WbAlu;
					result.ctrl.mulWide  = 1'b1;
				end
				default: begin
					result.ctrl.wbSrc    = (op == OpMovr) ? WbMove : WbAlu;
					result.ctrl.writeEn1 = !onSecondPort(regA);
					result.ctrl.writeEn2 = onSecondPort(regA);
				end
			endcase
		end else if (memGroup && ((fnCode == FnMovmr) || (fnCode == FnMovrm))) begin
			// Address comes from regB, data register is regA
			result.claim         = 1'b1;
			result.ctrl.readSel1 = regA;
			result.ctrl.readSel2 = regB;
			result.ctrl.destSel  = regA;
			result.ctrl.destSel2 = regA;

			if (fnCode == FnMovmr) begin
				result.ctrl.memRead  = 1'b1;
				result.ctrl.wbSrc    = WbMem;
				result.ctrl.writeEn1 = !onSecondPort(regA);
				result.ctrl.writeEn2 = onSecondPort(regA);
			end else begin
				result.ctrl.memWrite = 1'b1;
			end
		end
	end

	// One memory access direction per instruction
	always_comb begin
		if (result.claim) begin
			assert (!(result.ctrl.memRead && result.ctrl.memWrite))
				else $error("aluDecoder: memRead and memWrite set together");
		end
	end

endmodule

`default_nettype wire

//--- hw/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	import isaPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Datapath selects
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		BSrcReg,
		BSrcImm
	} bSrc_t;

	// Write-back source
	typedef enum logic [2:0] {
		WbNone = 3'd0,
		WbAlu  = 3'd1,
		WbMove = 3'd2,
		WbMem  = 3'd3,
		WbPc   = 3'd4
	} wbSrc_t;

	typedef enum logic [1:0] {
		PcNext  = 2'd0,
		PcJump  = 2'd1,
		PcStack = 2'd2
	} pcSrc_t;

	typedef struct packed {
		aluOp_t  aluOp;
		bSrc_t   bSrc;
		wbSrc_t  wbSrc;
		pcSrc_t  pcSrc;
		logic    writeEn1;
		logic    writeEn2;
		regSel_t destSel;
		regSel_t destSel2;
		regSel_t readSel1;
		regSel_t readSel2;
		imm_t    immediate;
		imm_t    addr;
		logic    flagWrite;
		logic    memRead;
		logic    memWrite;
		logic    ret;
		logic    mulWide;
	} ctrlWord_t;

	typedef struct packed {
		logic      claim;
		ctrlWord_t ctrl;
	} decodeResult_t;

	// Nothing written, PC simply advances
	localparam ctrlWord_t IdleCtrl = '{
		aluOp:     4'd0,
		bSrc:      BSrcReg,
		wbSrc:     WbNone,
		pcSrc:     PcNext,
		writeEn1:  1'b0,
		writeEn2:  1'b0,
		destSel:   4'd0,
		destSel2:  4'd0,
		readSel1:  4'd0,
		readSel2:  4'd0,
		immediate: 16'd0,
		addr:      16'd0,
		flagWrite: 1'b0,
		memRead:   1'b0,
		memWrite:  1'b0,
		ret:       1'b0,
		mulWide:   1'b0
	};

endpackage

`default_nettype wire

//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction word and its fields
	//////////////////////////////////////////////////////////////////////

	typedef logic [17:0] instWord_t;
	typedef logic [3:0]  regSel_t;
	typedef logic [3:0]  aluOp_t;
	typedef logic [15:0] imm_t;
	typedef logic [2:0]  flags_t;
	typedef logic [1:0]  instClass_t;
	typedef logic [3:0]  group_t;
	typedef logic [3:0]  specOp_t;
	typedef logic [4:0]  jumpOp_t;

	// Flag bit positions
	localparam int FlagLow  = 2;
	localparam int FlagNeg  = 1;
	localparam int FlagZero = 0;

	// Class in bits 17..16
	localparam instClass_t ClsNormal = 2'b00;
	localparam instClass_t ClsSpecLo = 2'b01;
	localparam instClass_t ClsSpecHi = 2'b10;

	// Normal class, bits 15..12
	localparam group_t GrpRegForm = 4'd0;
	localparam group_t GrpRegOnly = 4'd1;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam aluOp_t OpAdd  = 4'd2;
	localparam aluOp_t OpSub  = 4'd3;
	localparam aluOp_t OpAnd  = 4'd4;
	localparam aluOp_t OpOr   = 4'd5;
	localparam aluOp_t OpXor  = 4'd6;
	localparam aluOp_t OpNot  = 4'd7;
	localparam aluOp_t OpLsh  = 4'd8;
	localparam aluOp_t OpRsh  = 4'd9;
	localparam aluOp_t OpArsh = 4'd10;
	localparam aluOp_t OpFmul = 4'd11;
	localparam aluOp_t OpMul  = 4'd12;
	localparam aluOp_t OpCmp  = 4'd13;
	localparam aluOp_t OpCmpr = 4'd14;
	localparam aluOp_t OpMovr = 4'd15;

	// Register-only group, function in bits 7..4
	localparam aluOp_t FnMovmr = 4'd0;
	localparam aluOp_t FnMovrm = 4'd1;

	// Special class, bits 17..14
	localparam specOp_t OpCall   = 4'd4;
	localparam specOp_t OpMovmri = 4'd5;
	localparam specOp_t OpMovrmi = 4'd6;
	localparam specOp_t OpRet    = 4'd7;

	// Jumps, bits 17..13
	localparam jumpOp_t OpJl  = 5'd16;
	localparam jumpOp_t OpJle = 5'd17;
	localparam jumpOp_t OpJne = 5'd18;
	localparam jumpOp_t OpJe  = 5'd19;
	localparam jumpOp_t OpJ   = 5'd20;
	localparam jumpOp_t OpJbe = 5'd21;
	localparam jumpOp_t OpJb  = 5'd22;

	// Registers with a fixed role
	localparam regSel_t MulHiReg     = 4'd11;
	localparam regSel_t SecondPortLo = 4'd12;
	localparam regSel_t StackPtrReg  = 4'd13;
	localparam regSel_t PcReg        = 4'd15;

endpackage

`default_nettype wire
